// ==== hdl/had_ddc_pkg.sv ====
/*
 * shared definitions for the debug download channel
 * data widths, address step and executor latency
 * debug register select, controller state and injected op enums
 */

package had_ddc_pkg;

  //====================
  // widths and timing
  //====================
  localparam int xlen = 32;                        // data, addr, operand width
  localparam logic [xlen-1:0] addr_step = 32'd4;   // word stride per store
  localparam int exec_lat = 3;                     // inject to retire cycles
  localparam int exec_cnt_w = $clog2(exec_lat + 1); // executor countdown width

  //====================
  // debug register targets
  //====================
  typedef enum logic [1:0] {
    dr_hcr   = 2'd0,   // control, bit 0 = download enable
    dr_daddr = 2'd1,   // download address
    dr_ddata = 2'd2    // download data
  } dr_sel_e;

  //====================
  // download controller states
  //====================
  typedef enum logic [3:0] {
    st_idle       = 4'h0,
    st_addr_wait  = 4'h1,   // wait first address from host
    st_addr_ld    = 4'h2,   // inject mov r0
    st_data_wait  = 4'h3,   // wait mov r0 retire and host data
    st_data_ld    = 4'h4,   // inject mov r1
    st_stw_wait   = 4'h5,   // wait mov r1 retire
    st_stw_ld     = 4'h6,   // inject stw r1, r0
    st_stw_finish = 4'h7,   // wait store retire
    st_addr_gen   = 4'h8    // step running address
  } ddc_state_e;

  // injected instruction kinds
  typedef enum logic [1:0] {
    op_mov_r0 = 2'd0,
    op_mov_r1 = 2'd1,
    op_stw    = 2'd2
  } inj_op_e;

endpackage

// ==== hdl/had_dr_regs.sv ====
/*
 * debug register file
 * decodes host update strobes into the enable bit,
 * the address and data values and their write strobes
 */

`timescale 1ns/1ps

module had_dr_regs import had_ddc_pkg::*; (
  input  logic            cpuclk,
  input  logic            cpurst_b,
  input  logic            dr_update,   // update-DR strobe from host
  input  dr_sel_e         dr_sel,
  input  logic [xlen-1:0] dr_value,
  output logic            ddc_en,
  output logic            daddr_wr,
  output logic            ddata_wr,
  output logic [xlen-1:0] daddr_val,
  output logic [xlen-1:0] ddata_val
);

  logic hcr_hit;
  logic daddr_hit;
  logic ddata_hit;

  // target decode, only while strobe is up
  assign hcr_hit   = dr_update && (dr_sel == dr_hcr);
  assign daddr_hit = dr_update && (dr_sel == dr_daddr);
  assign ddata_hit = dr_update && (dr_sel == dr_ddata);

  //====================
  // register storage
  //====================
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ddc_en    <= 1'b0;
      daddr_val <= '0;
      ddata_val <= '0;
    end
    else
    begin
      if (hcr_hit)
        ddc_en <= dr_value[0];   // only enable bit kept
      if (daddr_hit)
        daddr_val <= dr_value;
      if (ddata_hit)
        ddata_val <= dr_value;
    end
  end

  // write strobes, same cycle as the stored value
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      daddr_wr <= 1'b0;
      ddata_wr <= 1'b0;
    end
    else
    begin
      daddr_wr <= daddr_hit;
      ddata_wr <= ddata_hit;
    end
  end

endmodule

// ==== hdl/had_ddc_ctrl.sv ====
/*
 * download controller FSM
 * sequences mov r0 (address), mov r1 (data) and stw r1, r0
 * and steps the address after each store
 */

`timescale 1ns/1ps

module had_ddc_ctrl import had_ddc_pkg::*; (
  input  logic cpuclk,
  input  logic cpurst_b,
  input  logic ddc_en,     // download enable level
  input  logic daddr_wr,   // new address from host
  input  logic ddata_wr,   // new data from host
  input  logic retire,     // injected instruction retired
  output logic addr_sel,
  output logic data_sel,
  output logic stw_sel,
  output logic addr_gen
);

  ddc_state_e cur_st;
  ddc_state_e nxt_st;
  logic       addr_ld_finish;   // mov r0 has retired in data wait
  logic       addr_ready;
  logic       data_ready;

  assign addr_ready = daddr_wr;
  assign data_ready = ddata_wr;

  //====================
  // state register
  //====================
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_st <= st_idle;
    else
      cur_st <= nxt_st;
  end

  //====================
  // next state
  //====================
  always_comb
  begin
    nxt_st = cur_st;   // hold by default
    case (cur_st)
      st_idle:
        if (ddc_en)
          nxt_st = st_addr_wait;
      st_addr_wait:
        if (addr_ready)
          nxt_st = st_addr_ld;
      st_addr_ld:
        nxt_st = st_data_wait;   // mov r0 goes out this cycle
      st_data_wait:
      begin
        if (addr_ld_finish && data_ready)
          nxt_st = st_data_ld;
        else if (addr_ready)
          nxt_st = st_addr_ld;   // host rewrote base
        else if (!ddc_en)
          nxt_st = st_idle;
      end
      st_data_ld:
        nxt_st = st_stw_wait;    // mov r1 goes out
      st_stw_wait:
        if (retire)
          nxt_st = st_stw_ld;    // data now in r1
      st_stw_ld:
        nxt_st = st_stw_finish;  // stw goes out
      st_stw_finish:
        if (retire)
          nxt_st = st_addr_gen;
      st_addr_gen:
        nxt_st = st_addr_ld;     // reload stepped address
      default:
        nxt_st = st_idle;
    endcase
  end

  // addr load finish flag
  // only meaningful while waiting for data, dropped elsewhere
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      addr_ld_finish <= 1'b0;
    else if (cur_st == st_data_wait)
    begin
      if (retire)
        addr_ld_finish <= 1'b1;
    end
    else
      addr_ld_finish <= 1'b0;
  end

  //====================
  // selects to datapath
  //====================
  assign addr_sel = (cur_st == st_addr_ld);
  assign data_sel = (cur_st == st_data_ld);
  assign stw_sel  = (cur_st == st_stw_ld);
  assign addr_gen = (cur_st == st_addr_gen);

endmodule

// ==== hdl/had_ddc_dp.sv ====
/*
 * download datapath
 * running address register and address step
 * turns controller selects into one injected op and operand
 */

`timescale 1ns/1ps

module had_ddc_dp import had_ddc_pkg::*; (
  input  logic            cpuclk,
  input  logic            cpurst_b,
  input  logic            daddr_wr,
  input  logic [xlen-1:0] daddr_val,
  input  logic [xlen-1:0] ddata_val,
  input  logic            addr_sel,
  input  logic            data_sel,
  input  logic            stw_sel,
  input  logic            addr_gen,
  output logic            inj_valid,
  output inj_op_e         inj_op,
  output logic [xlen-1:0] inj_operand
);

  logic [xlen-1:0] run_addr;   // next store address

  //====================
  // running address
  //====================
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      run_addr <= '0;
    else if (daddr_wr)
      run_addr <= daddr_val;   // host base wins
    else if (addr_gen)
      run_addr <= run_addr + addr_step;
  end

  //====================
  // injection
  //====================
  assign inj_valid = addr_sel || data_sel || stw_sel;

  // selects are one-hot from the FSM
  always_comb
  begin
    inj_op      = op_mov_r0;
    inj_operand = '0;
    if (addr_sel)
    begin
      inj_op      = op_mov_r0;
      inj_operand = run_addr;    // base into r0
    end
    else if (data_sel)
    begin
      inj_op      = op_mov_r1;
      inj_operand = ddata_val;   // data into r1
    end
    else if (stw_sel)
    begin
      inj_op      = op_stw;      // regs only, no operand
      inj_operand = '0;
    end
  end

endmodule

// ==== hdl/had_inst_exec.sv ====
/*
 * fixed latency executor for injected instructions
 * holds r0 and r1, retires after exec_lat cycles
 * and drives the store bus for stw
 */

`timescale 1ns/1ps

module had_inst_exec import had_ddc_pkg::*; (
  input  logic            cpuclk,
  input  logic            cpurst_b,
  input  logic            inj_valid,
  input  inj_op_e         inj_op,
  input  logic [xlen-1:0] inj_operand,
  output logic            retire,
  output logic            st_en,
  output logic [xlen-1:0] st_addr,
  output logic [xlen-1:0] st_data
);

  logic                  busy;      // one instruction in flight
  logic [exec_cnt_w-1:0] cnt;       // cycles left to retire
  inj_op_e               op_q;      // latched op
  logic [xlen-1:0]       opnd_q;    // latched operand
  logic [xlen-1:0]       r0;        // address reg
  logic [xlen-1:0]       r1;        // data reg

  //====================
  // in-flight tracking
  //====================
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      busy <= 1'b0;
      cnt  <= '0;
    end
    else if (inj_valid)
    begin
      busy <= 1'b1;
      cnt  <= exec_cnt_w'(exec_lat - 1);   // restart on new injection
    end
    else if (retire)
      busy <= 1'b0;
    else if (busy)
      cnt <= cnt - 1'b1;
  end

  // payload latch
  always_ff @(posedge cpuclk)
  begin
    if (inj_valid)
    begin
      op_q   <= inj_op;
      opnd_q <= inj_operand;
    end
  end

  assign retire = busy && (cnt == '0);

  //====================
  // register writeback
  //====================
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      r0 <= '0;
      r1 <= '0;
    end
    else if (retire)
    begin
      if (op_q == op_mov_r0)
        r0 <= opnd_q;
      if (op_q == op_mov_r1)
        r1 <= opnd_q;
    end
  end

  // store bus, stw r1, r0
  assign st_en   = retire && (op_q == op_stw);
  assign st_addr = r0;
  assign st_data = r1;

endmodule

// ==== hdl/had_ddc_top.sv ====
/*
 * debug download channel top
 * debug regs, controller, datapath and executor
 */

`timescale 1ns/1ps

module had_ddc_top import had_ddc_pkg::*; (
  input  logic            cpuclk,
  input  logic            cpurst_b,
  input  logic            dr_update,
  input  dr_sel_e         dr_sel,
  input  logic [xlen-1:0] dr_value,
  output logic            st_en,
  output logic [xlen-1:0] st_addr,
  output logic [xlen-1:0] st_data
);

  logic            ddc_en;
  logic            daddr_wr;
  logic            ddata_wr;
  logic [xlen-1:0] daddr_val;
  logic [xlen-1:0] ddata_val;
  logic            addr_sel;
  logic            data_sel;
  logic            stw_sel;
  logic            addr_gen;
  logic            inj_valid;
  inj_op_e         inj_op;
  logic [xlen-1:0] inj_operand;
  logic            retire;

  //====================
  // host side registers
  //====================
  had_dr_regs regs_i (
    .cpuclk    (cpuclk),
    .cpurst_b  (cpurst_b),
    .dr_update (dr_update),
    .dr_sel    (dr_sel),
    .dr_value  (dr_value),
    .ddc_en    (ddc_en),
    .daddr_wr  (daddr_wr),
    .ddata_wr  (ddata_wr),
    .daddr_val (daddr_val),
    .ddata_val (ddata_val)
  );

  // sequencing
  had_ddc_ctrl ctrl_i (
    .cpuclk   (cpuclk),
    .cpurst_b (cpurst_b),
    .ddc_en   (ddc_en),
    .daddr_wr (daddr_wr),
    .ddata_wr (ddata_wr),
    .retire   (retire),
    .addr_sel (addr_sel),
    .data_sel (data_sel),
    .stw_sel  (stw_sel),
    .addr_gen (addr_gen)
  );

  had_ddc_dp dp_i (
    .cpuclk      (cpuclk),
    .cpurst_b    (cpurst_b),
    .daddr_wr    (daddr_wr),
    .daddr_val   (daddr_val),
    .ddata_val   (ddata_val),
    .addr_sel    (addr_sel),
    .data_sel    (data_sel),
    .stw_sel     (stw_sel),
    .addr_gen    (addr_gen),
    .inj_valid   (inj_valid),
    .inj_op      (inj_op),
    .inj_operand (inj_operand)
  );

  //====================
  // core stand-in
  //====================
  had_inst_exec exec_i (
    .cpuclk      (cpuclk),
    .cpurst_b    (cpurst_b),
    .inj_valid   (inj_valid),
    .inj_op      (inj_op),
    .inj_operand (inj_operand),
    .retire      (retire),
    .st_en       (st_en),
    .st_addr     (st_addr),
    .st_data     (st_data)
  );

endmodule

// ==== bench/had_ddc_tb.sv ====
/*
 * testbench for the debug download channel
 * stimulus table with LFSR data words, store stream model,
 * store monitor and cycle watchdog
 */

`timescale 1ns/1ps

module had_ddc_tb import had_ddc_pkg::*; ();

  localparam int max_rows = 32;
  localparam int st_lat   = 2 * exec_lat + 3;   // data update to st_en
  localparam int addr_lat = exec_lat + 2;       // address update until mov r0 retired

  logic            cpuclk = 1'b0;
  logic            cpurst_b;
  logic            dr_update;
  dr_sel_e         dr_sel;
  logic [xlen-1:0] dr_value;
  logic            st_en;
  logic [xlen-1:0] st_addr;
  logic [xlen-1:0] st_data;

  //====================
  // stimulus table
  //====================
  dr_sel_e         row_sel [max_rows];
  logic [xlen-1:0] row_val [max_rows];
  int              row_gap [max_rows];   // cycles to next update
  bit              row_st [max_rows];    // row should give a store
  int              n_rows = 0;

  // expected store stream, filled by the model
  logic [xlen-1:0] exp_addr_q [$];
  logic [xlen-1:0] exp_data_q [$];
  int              exp_cyc_q [$];

  bit              m_en = 1'b0;         // model enable
  bit              m_addr_vld = 1'b0;   // address known since enable
  logic [xlen-1:0] m_addr = '0;         // running address
  int              m_addr_t = 0;        // cycle of last address load

  logic [31:0]     lfsr;
  int              cyc = 0;
  int              cyc_limit = 1000000;
  int              rd_idx = 0;          // monitor position in queue
  int              mon_err = 0;
  int              stim_err = 0;
  int              st_seen = 0;

  always #50 cpuclk = ~cpuclk;

  always @(posedge cpuclk)
    cyc <= cyc + 1;

  had_ddc_top dut_i (
    .cpuclk    (cpuclk),
    .cpurst_b  (cpurst_b),
    .dr_update (dr_update),
    .dr_sel    (dr_sel),
    .dr_value  (dr_value),
    .st_en     (st_en),
    .st_addr   (st_addr),
    .st_data   (st_data)
  );

  // galois step, taps 0xb4bcd35c
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'hb4bc_d35c;
    return s >> 1;
  endfunction

  task automatic next_word(output logic [xlen-1:0] w);
    w = '0;
    for (int b = 0; b < xlen; b++)
    begin
      w    = {w[xlen-2:0], lfsr[0]};   // one step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic add_row(input dr_sel_e sel, input logic [xlen-1:0] val,
                         input int gap, input bit want_st);
    row_sel[n_rows] = sel;
    row_val[n_rows] = val;
    row_gap[n_rows] = gap;
    row_st[n_rows]  = want_st;
    n_rows++;
  endtask

  task automatic add_lfsr_row(input int gap, input bit want_st);
    logic [xlen-1:0] w;
    next_word(w);
    add_row(dr_ddata, w, gap, want_st);
  endtask

  //====================
  // test sequence
  //====================
  task automatic build_table();
    add_row(dr_daddr, 32'h0000_1000, 6, 1'b0);    // enable still clear
    add_row(dr_ddata, 32'hdead_0001, 12, 1'b0);
    add_row(dr_hcr, 32'h1, 3, 1'b0);              // single store
    add_row(dr_daddr, 32'h0000_2000, 6, 1'b0);
    add_row(dr_ddata, 32'h1234_5678, 16, 1'b1);
    add_row(dr_daddr, 32'h0000_3000, 6, 1'b0);    // eight word stream
    for (int k = 0; k < 8; k++)
      add_lfsr_row(16, 1'b1);
    add_row(dr_daddr, 32'h0000_4000, 2, 1'b0);    // data too early
    add_lfsr_row(8, 1'b0);
    add_lfsr_row(16, 1'b1);
    add_row(dr_daddr, 32'h0000_5000, 7, 1'b0);    // base rewrite
    add_row(dr_daddr, 32'h0000_6000, 6, 1'b0);
    add_lfsr_row(16, 1'b1);
    add_row(dr_hcr, 32'h0, 4, 1'b0);              // disable in data wait
    add_lfsr_row(16, 1'b0);
    add_row(dr_hcr, 32'h1, 3, 1'b0);
    add_row(dr_daddr, 32'h0000_7000, 6, 1'b0);
    add_lfsr_row(16, 1'b1);
    add_lfsr_row(16, 1'b1);
  endtask

  // store stream model, called once per host update
  task automatic track_update(input dr_sel_e sel, input logic [xlen-1:0] val,
                              input int now, input bit want_st);
    bit hit;
    hit = 1'b0;
    case (sel)
      dr_hcr:
      begin
        m_en = val[0];
        if (!val[0])
          m_addr_vld = 1'b0;   // needs a fresh base after re-enable
      end
      dr_daddr:
        if (m_en)
        begin
          m_addr     = val;
          m_addr_t   = now;
          m_addr_vld = 1'b1;
        end
      dr_ddata:
        if (m_en && m_addr_vld && (now - m_addr_t >= addr_lat))
        begin
          hit = 1'b1;
          exp_addr_q.push_back(m_addr);
          exp_data_q.push_back(val);
          exp_cyc_q.push_back(now + st_lat);
          m_addr   = m_addr + addr_step;
          m_addr_t = now + st_lat;   // stepped mov r0 starts at the store
        end
      default:
        hit = 1'b0;
    endcase
    if (hit != want_st)
    begin
      $display("table and model disagree on a store for data 0x%h at time %0t", val, $time);
      stim_err++;
    end
  endtask

  task automatic report_counts();
    $display("stores expected %0d, seen %0d, store errors %0d, table errors %0d",
             exp_cyc_q.size(), st_seen, mon_err, stim_err);
  endtask

  //====================
  // store monitor
  //====================
  always @(negedge cpuclk)
  begin
    if (cpurst_b)
    begin
      if ((rd_idx < exp_cyc_q.size()) && (cyc > exp_cyc_q[rd_idx]))
      begin
        $display("store of 0x%h to 0x%h did not appear in cycle %0d",
                 exp_data_q[rd_idx], exp_addr_q[rd_idx], exp_cyc_q[rd_idx]);
        mon_err++;
        rd_idx++;
      end
      if (st_en)
      begin
        st_seen++;
        if (rd_idx >= exp_cyc_q.size())
        begin
          $display("store of 0x%h to 0x%h at time %0t was not expected", st_data, st_addr, $time);
          mon_err++;
        end
        else
        begin
          if (cyc != exp_cyc_q[rd_idx])
          begin
            $display("Error: time %0t, st_en cycle expected %0d, actual %0d",
                     $time, exp_cyc_q[rd_idx], cyc);
            mon_err++;
          end
          if (st_addr != exp_addr_q[rd_idx])
          begin
            $display("Error: time %0t, st_addr expected 0x%h, actual 0x%h",
                     $time, exp_addr_q[rd_idx], st_addr);
            mon_err++;
          end
          if (st_data != exp_data_q[rd_idx])
          begin
            $display("Error: time %0t, st_data expected 0x%h, actual 0x%h",
                     $time, exp_data_q[rd_idx], st_data);
            mon_err++;
          end
          rd_idx++;
        end
      end
    end
  end

  // watchdog
  always @(negedge cpuclk)
  begin
    if (cyc >= cyc_limit)
    begin
      $display("run did not finish within %0d cycles", cyc_limit);
      report_counts();
      $display("*** FAILED ***");
      $finish;
    end
  end

  //====================
  // main sequence
  //====================
  initial
  begin
    int last_due;
    dr_update <= 1'b0;
    dr_sel    <= dr_hcr;
    dr_value  <= '0;
    cpurst_b  <= 1'b0;
    lfsr = 32'h5b1cab62;
    build_table();
    cyc_limit = 0;
    for (int i = 0; i < n_rows; i++)
      cyc_limit += row_gap[i] + 20;
    repeat (4) @(posedge cpuclk);
    cpurst_b <= 1'b1;
    for (int i = 0; i < n_rows; i++)
    begin
      @(posedge cpuclk);
      dr_update <= 1'b1;
      dr_sel    <= row_sel[i];
      dr_value  <= row_val[i];
      @(negedge cpuclk);
      track_update(row_sel[i], row_val[i], cyc, row_st[i]);
      repeat (row_gap[i] - 1)
      begin
        @(posedge cpuclk);
        dr_update <= 1'b0;
      end
    end
    @(posedge cpuclk);
    dr_update <= 1'b0;
    last_due = (exp_cyc_q.size() > 0) ? exp_cyc_q[$] : cyc;
    while (cyc <= last_due + st_lat)   // room for stray stores
      @(negedge cpuclk);
    if (rd_idx < exp_cyc_q.size())
    begin
      $display("%0d expected stores never appeared", exp_cyc_q.size() - rd_idx);
      mon_err++;
    end
    report_counts();
    if (mon_err + stim_err == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/had_ddc_pkg.sv
hdl/had_dr_regs.sv
hdl/had_ddc_ctrl.sv
hdl/had_ddc_dp.sv
hdl/had_inst_exec.sv
hdl/had_ddc_top.sv
bench/had_ddc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the debug download channel testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module had_ddc_tb -Mdir obj_dir -o had_ddc_sim

./obj_dir/had_ddc_sim | tee sim.log

# verdict comes from the log
if grep -qF '*** FAILED ***' sim.log
then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
